// File: Makefile
# Verilator flow for rv_core

VERILATOR   ?= verilator
TOP         ?= rv_core_tb
FILELIST    ?= rv_core.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides, not the exit status of the binary
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/rv_core_assertions.sv
/* rv_core handshake checks */

`timescale 1ns/1ps

module rv_core_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 imem_req,
    input logic                 imem_valid,
    input logic                 retire,
    input logic                 retire_we,
    input rv_isa_pkg::reg_idx_t retire_rd
);

    logic pending;  // request out, answer not yet seen

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (imem_req) begin
            pending <= 1'b1;
        end else if (imem_valid) begin
            pending <= 1'b0;
        end
    end

    req_one_cycle: assert property (@(posedge clk) disable iff (reset)
        imem_req |=> !imem_req)
        else $error("imem_req held for more than one cycle");

    // only one fetch in flight
    no_req_while_pending: assert property (@(posedge clk) disable iff (reset)
        imem_req |-> !pending)
        else $error("imem_req issued while a response was still pending");

    retire_after_valid: assert property (@(posedge clk) disable iff (reset)
        pending && imem_valid |=> retire)
        else $error("retire did not follow imem_valid");

    retire_needs_valid: assert property (@(posedge clk) disable iff (reset)
        retire |-> $past(imem_valid))
        else $error("retire without imem_valid in the cycle before");

    we_nonzero_rd: assert property (@(posedge clk) disable iff (reset)
        retire && retire_we |-> retire_rd != 5'd0)
        else $error("retire_we set with retire_rd equal to x0");

endmodule

bind rv_core_top rv_core_assertions u_assertions (
    .clk(clk),
    .reset(reset),
    .imem_req(imem_req),
    .imem_valid(imem_valid),
    .retire(retire),
    .retire_we(retire_we),
    .retire_rd(retire_rd)
);

// File: dv/rv_core_tb.sv
/* rv_core random instruction testbench */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_tb;
    import rv_isa_pkg::*;

    localparam int NUM_INSTR  = 400;
    localparam int WAIT_LIMIT = 16;  // cycles before a wait gives up

    logic     clk = 1'b0;
    logic     reset;
    logic     imem_valid;
    word_t    imem_data;
    logic     imem_req;
    addr_t    imem_addr;
    logic     retire;
    addr_t    retire_pc;
    reg_idx_t retire_rd;
    logic     retire_we;
    word_t    retire_wdata;
    addr_t    retire_next_pc;

    word_t       model_regs [32];
    addr_t       model_pc;
    logic [31:0] lcg_state;
    int          errors;
    int          checks;

    // fields of the instruction in flight
    opcode_t  f_op;
    reg_idx_t f_rd, f_rs1, f_rs2;
    funct3_t  f_f3;
    logic     f_alt;  // sub or sra
    word_t    f_imm;

    rv_core_top dut0 (
        .clk(clk), .reset(reset),
        .imem_valid(imem_valid), .imem_data(imem_data),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .retire(retire), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_wdata(retire_wdata),
        .retire_next_pc(retire_next_pc)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // value in 0..n-1, upper bits only
    function automatic int unsigned pick(input int unsigned n);
        logic [31:0] r;
        r = next_random();
        return {8'b0, r[31:8]} % n;
    endfunction

    function automatic word_t model_read(input reg_idx_t idx);
        return (idx == 5'd0) ? 32'd0 : model_regs[idx];
    endfunction

    // signed compare by flipping the sign bits
    function automatic logic signed_less(input word_t a, input word_t b);
        return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    function automatic word_t alu_ref(input funct3_t f3, input logic alt,
                                      input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;  // sign bits for sra
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, signed_less(a, b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? ((a >> sh) | fill) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return signed_less(a, b);
            3'd5:    return !signed_less(a, b);
            3'd6:    return a < b;
            default: return !(a < b);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%0t ns: %s", $time, what);
        end
    endtask

    // registers x0..x7 only, so results get reused often
    task automatic build_instr(output word_t word);
        int unsigned kind;
        int unsigned v;
        int          off;
        logic [11:0] imm12;
        logic [31:0] r;
        kind  = pick(19);
        r     = next_random();
        f_rd  = 5'(pick(8));
        f_rs1 = 5'(pick(8));
        f_rs2 = 5'(pick(8));
        f_f3  = 3'(pick(8));
        f_alt = 1'b0;
        f_imm = '0;
        off   = (int'(pick(33)) - 16) * 4;  // branch and jal offset
        if (kind < 6) begin
            f_op  = `RV_OP_OP;
            f_alt = (f_f3 == 3'd0 || f_f3 == 3'd5) && pick(2) == 1;
            word  = {1'b0, f_alt, 5'b0, f_rs2, f_rs1, f_f3, f_rd, f_op};
        end else if (kind < 11) begin
            f_op  = `RV_OP_OP_IMM;
            imm12 = r[11:0];
            if (f_f3 == 3'd1 || f_f3 == 3'd5) begin
                f_alt = (f_f3 == 3'd5) && pick(2) == 1;
                imm12 = {1'b0, f_alt, 5'b0, r[4:0]};  // shift amount only
            end
            f_imm = {{20{imm12[11]}}, imm12};
            word  = {imm12, f_rs1, f_f3, f_rd, f_op};
        end else if (kind < 13) begin
            f_op  = (kind == 11) ? `RV_OP_LUI : `RV_OP_AUIPC;
            f_imm = {r[31:12], 12'b0};
            word  = {f_imm[31:12], f_rd, f_op};
        end else if (kind < 16) begin
            v     = pick(6);
            f_f3  = (v < 2) ? 3'(v) : 3'(v + 2);  // skip the two unused codes
            f_op  = `RV_OP_BRANCH;
            f_imm = off;
            word  = {f_imm[12], f_imm[10:5], f_rs2, f_rs1, f_f3,
                     f_imm[4:1], f_imm[11], f_op};
        end else if (kind == 16) begin
            f_op  = `RV_OP_JAL;
            f_imm = off;
            word  = {f_imm[20], f_imm[10:1], f_imm[11], f_imm[19:12], f_rd, f_op};
        end else if (kind == 17) begin
            // odd offsets too, target drops bit 0
            f_op  = `RV_OP_JALR;
            f_imm = int'(pick(64)) - 32;
            word  = {f_imm[11:0], f_rs1, 3'b000, f_rd, f_op};
        end else begin
            v    = pick(4);
            f_op = (v == 0) ? 7'b0000011 : (v == 1) ? 7'b0100011 :
                   (v == 2) ? 7'b1110011 : 7'b0001111;  // load, store, system, fence
            word = {r[31:7], f_op};
        end
    endtask

    task automatic check_retire();
        word_t a, b, exp_wdata;
        addr_t exp_next;
        logic  exp_we;
        a         = model_read(f_rs1);
        b         = model_read(f_rs2);
        exp_we    = 1'b0;
        exp_wdata = '0;
        exp_next  = model_pc + 32'd4;
        case (f_op)
            `RV_OP_OP: begin
                exp_we    = 1'b1;
                exp_wdata = alu_ref(f_f3, f_alt, a, b);
            end
            `RV_OP_OP_IMM: begin
                exp_we    = 1'b1;
                exp_wdata = alu_ref(f_f3, f_alt, a, f_imm);
            end
            `RV_OP_LUI: begin
                exp_we    = 1'b1;
                exp_wdata = f_imm;
            end
            `RV_OP_AUIPC: begin
                exp_we    = 1'b1;
                exp_wdata = model_pc + f_imm;
            end
            `RV_OP_JAL: begin
                exp_we    = 1'b1;
                exp_wdata = model_pc + 32'd4;
                exp_next  = model_pc + f_imm;
            end
            `RV_OP_JALR: begin
                exp_we    = 1'b1;
                exp_wdata = model_pc + 32'd4;
                exp_next  = (a + f_imm) & ~32'd1;
            end
            `RV_OP_BRANCH: begin
                if (branch_taken(f_f3, a, b)) begin
                    exp_next = model_pc + f_imm;
                end
            end
            default: ;  // unknown opcode is a no-op
        endcase
        if (f_rd == 5'd0) begin
            exp_we = 1'b0;
        end
        check_value("retire_pc", retire_pc, model_pc);
        check_value("retire_we", 32'(retire_we), 32'(exp_we));
        check_value("retire_next_pc", retire_next_pc, exp_next);
        if (exp_we) begin
            check_value("retire_rd", 32'(retire_rd), 32'(f_rd));
            check_value("retire_wdata", retire_wdata, exp_wdata);
            model_regs[f_rd] = exp_wdata;
        end
        model_pc = exp_next;
    endtask

    // cycles until imem_req, 0 on timeout
    task automatic wait_request(output int cycles);
        int n;
        n      = 0;
        cycles = 0;
        while (cycles == 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
            if (imem_req) begin
                cycles = n;
            end
        end
    endtask

    task automatic respond(input word_t word, input int unsigned latency);
        int unsigned k;
        k = 0;
        while (k < latency) begin
            @(posedge clk);
            #1;
            k++;
            check_true(!imem_req && !retire, "request or retire while a response was pending");
            if (k == latency) begin
                imem_valid = 1'b1;
                imem_data  = word;
            end
        end
    endtask

    // drops imem_valid, then counts cycles until retire
    task automatic wait_retire(output int cycles);
        int n;
        n      = 0;
        cycles = 0;
        while (cycles == 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            imem_valid = 1'b0;
            n++;
            if (retire) begin
                cycles = n;
            end
        end
    endtask

    initial begin
        int          cycles;
        int          count;
        int          i;
        int unsigned latency;
        logic        hung;
        word_t       word;
        $timeformat(-9, 0, "", 0);
        lcg_state  = 32'h2969_5791;
        errors     = 0;
        checks     = 0;
        hung       = 1'b0;
        count      = 0;
        model_pc   = `RV_RESET_PC;
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_data  = '0;
        for (i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) begin
            @(posedge clk);
            #1;
            check_true(!imem_req && !retire, "imem_req or retire high during reset");
        end
        reset = 1'b0;
        while (!hung && count < NUM_INSTR) begin
            wait_request(cycles);
            if (cycles == 0) begin
                $display("%0t ns: timeout, no imem_req after reset or retire", $time);
                errors++;
                hung = 1'b1;
            end else begin
                check_true(cycles == 1, "imem_req not issued in the cycle after reset or retire");
                check_value("imem_addr", imem_addr, model_pc);
                build_instr(word);
                latency = 1 + pick(4);
                respond(word, latency);
                wait_retire(cycles);
                if (cycles == 0) begin
                    $display("%0t ns: timeout, retire never came after imem_valid", $time);
                    errors++;
                    hung = 1'b1;
                end else begin
                    check_true(cycles == 1, "retire did not come one cycle after imem_valid");
                    check_retire();
                end
            end
            count++;
        end
        $display("rv_core_tb: %0d instructions, %0d checks, %0d errors", count, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: include/rv_core_defines.svh
/* rv_core widths and opcodes */

`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// datapath
`define RV_XLEN      32
`define RV_REG_COUNT 32

// first fetch after reset
`define RV_RESET_PC  32'h8000_0000

// major opcodes that the core executes
`define RV_OP_OP     7'b0110011  // register-register alu
`define RV_OP_OP_IMM 7'b0010011  // register-immediate alu
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011

`endif

// File: rv_core.f
// include path for the shared defines
+incdir+include
// packages
source/rv_isa_pkg.sv
source/rv_ctrl_pkg.sv
// rtl
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/gpr_file.sv
source/rv_core_top.sv
// testbench
dv/rv_core_assertions.sv
dv/rv_core_tb.sv

// File: source/decode_unit.sv
/* rv32i instruction decode */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module decode_unit (
    input  rv_isa_pkg::word_t     instr,
    output rv_isa_pkg::reg_idx_t  rs1,
    output rv_isa_pkg::reg_idx_t  rs2,
    output rv_isa_pkg::reg_idx_t  rd,
    output rv_isa_pkg::word_t     imm,
    output rv_ctrl_pkg::alu_op_t  alu_op,
    output rv_ctrl_pkg::src_a_t   src_a,
    output rv_ctrl_pkg::src_b_t   src_b,
    output rv_ctrl_pkg::flow_t    flow,
    output rv_ctrl_pkg::br_cond_t br_cond,
    output rv_ctrl_pkg::wb_sel_t  wb_sel,
    output logic                  reg_we
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    logic      funct7_b5;  // sub / sra select
    inst_fmt_t fmt;
    logic      writes;     // opcode writes rd

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];
    assign rd        = instr[11:7];
    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];

    always_comb begin
        fmt    = FMT_NONE;
        src_a  = SRC_A_RS1;
        src_b  = SRC_B_IMM;
        flow   = FLOW_SEQ;
        wb_sel = WB_ALU;
        writes = 1'b0;
        case (opcode)
            `RV_OP_OP: begin
                fmt    = FMT_R;
                src_b  = SRC_B_RS2;
                writes = 1'b1;
            end
            `RV_OP_OP_IMM: begin
                fmt    = FMT_I;
                writes = 1'b1;
            end
            `RV_OP_LUI: begin
                fmt    = FMT_U;
                src_a  = SRC_A_ZERO;  // 0 + imm
                writes = 1'b1;
            end
            `RV_OP_AUIPC: begin
                fmt    = FMT_U;
                src_a  = SRC_A_PC;
                writes = 1'b1;
            end
            `RV_OP_JAL: begin
                fmt    = FMT_J;
                flow   = FLOW_JAL;
                wb_sel = WB_LINK;
                writes = 1'b1;
            end
            `RV_OP_JALR: begin
                fmt    = FMT_I;
                flow   = FLOW_JALR;  // target from the alu sum
                wb_sel = WB_LINK;
                writes = 1'b1;
            end
            `RV_OP_BRANCH: begin
                fmt   = FMT_B;
                src_b = SRC_B_RS2;
                // funct3 010/011 are not branches, fall through as a no-op
                flow  = (funct3[2:1] == 2'b01) ? FLOW_SEQ : FLOW_BRANCH;
            end
            default: ;  // unknown opcode retires as a no-op
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        unique case (fmt)
            FMT_I:   imm = {{20{instr[31]}}, instr[31:20]};
            FMT_B:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            FMT_U:   imm = {instr[31:12], 12'b0};
            FMT_J:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;
        if (fmt == FMT_R || opcode == `RV_OP_OP_IMM) begin
            unique case (funct3)
                3'b000: alu_op = (fmt == FMT_R && funct7_b5) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = funct7_b5 ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                3'b111: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        unique case (funct3)
            3'b000:  br_cond = BR_EQ;
            3'b001:  br_cond = BR_NE;
            3'b100:  br_cond = BR_LT;
            3'b101:  br_cond = BR_GE;
            3'b110:  br_cond = BR_LTU;
            default: br_cond = BR_GEU;
        endcase
    end

    assign reg_we = writes && (rd != 5'd0);  // x0 stays zero

endmodule

// File: source/execute_unit.sv
/* alu, branch and next pc */

`timescale 1ns/1ps

module execute_unit (
    input  rv_isa_pkg::addr_t     pc,
    input  rv_isa_pkg::word_t     rs1_data,
    input  rv_isa_pkg::word_t     rs2_data,
    input  rv_isa_pkg::word_t     imm,
    input  rv_ctrl_pkg::alu_op_t  alu_op,
    input  rv_ctrl_pkg::src_a_t   src_a,
    input  rv_ctrl_pkg::src_b_t   src_b,
    input  rv_ctrl_pkg::flow_t    flow,
    input  rv_ctrl_pkg::br_cond_t br_cond,
    input  rv_ctrl_pkg::wb_sel_t  wb_sel,
    output rv_isa_pkg::word_t     wdata,
    output rv_isa_pkg::addr_t     next_pc
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    word_t      op_a, op_b;
    word_t      alu_res;
    logic [4:0] shamt;
    logic       taken;
    addr_t      pc_plus4;
    addr_t      pc_plus_imm;  // branch and jal target

    always_comb begin
        unique case (src_a)
            SRC_A_PC:   op_a = pc;
            SRC_A_ZERO: op_a = '0;  // lui
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b  = (src_b == SRC_B_IMM) ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = op_a + op_b;
        endcase
    end

    // compares the register values directly, not the alu operands
    always_comb begin
        unique case (br_cond)
            BR_EQ:   taken = (rs1_data == rs2_data);
            BR_NE:   taken = (rs1_data != rs2_data);
            BR_LT:   taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_GE:   taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_LTU:  taken = (rs1_data < rs2_data);
            BR_GEU:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4    = pc + 32'd4;
    assign pc_plus_imm = pc + imm;

    always_comb begin
        unique case (flow)
            FLOW_BRANCH: next_pc = taken ? pc_plus_imm : pc_plus4;
            FLOW_JAL:    next_pc = pc_plus_imm;
            FLOW_JALR:   next_pc = {alu_res[31:1], 1'b0};  // low bit dropped
            default:     next_pc = pc_plus4;
        endcase
    end

    assign wdata = (wb_sel == WB_LINK) ? pc_plus4 : alu_res;

endmodule

// File: source/fetch_unit.sv
/* pc and instruction fetch */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module fetch_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              imem_valid,
    input  rv_isa_pkg::word_t imem_data,
    input  rv_isa_pkg::addr_t next_pc,
    output logic              imem_req,
    output rv_isa_pkg::addr_t imem_addr,
    output rv_isa_pkg::addr_t pc,
    output rv_isa_pkg::word_t instr,
    output logic              exec_valid
);

    // issue only follows reset, later requests leave from execute
    typedef enum logic [1:0] {
        ST_ISSUE,
        ST_WAIT,
        ST_EXEC
    } fetch_state_t;

    fetch_state_t state, state_nxt;

    always_comb begin
        state_nxt = state;
        unique case (state)
            ST_ISSUE: state_nxt = ST_WAIT;
            ST_WAIT: begin
                if (imem_valid) begin  // response ends the wait
                    state_nxt = ST_EXEC;
                end
            end
            ST_EXEC:  state_nxt = ST_WAIT;  // next request goes out now
            default:  state_nxt = ST_ISSUE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_ISSUE;
        end else begin
            state <= state_nxt;
        end
    end

    // request strobe, one cycle after issue or execute
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            imem_req <= 1'b0;
        end else begin
            imem_req <= (state != ST_WAIT);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (state == ST_EXEC) begin
            pc <= next_pc;  // takes effect as the instruction retires
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT && imem_valid) begin
            instr <= imem_data;
        end
    end

    assign imem_addr  = pc;
    assign exec_valid = (state == ST_EXEC);

endmodule

// File: source/gpr_file.sv
/* general register file */

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module gpr_file (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    input  rv_isa_pkg::reg_idx_t rd,
    input  rv_isa_pkg::word_t    wdata,
    input  logic                 exec_valid,
    input  logic                 reg_we,
    output rv_isa_pkg::word_t    rs1_data,
    output rv_isa_pkg::word_t    rs2_data
);
    import rv_isa_pkg::*;

    word_t regs [`RV_REG_COUNT];

    // write lands on the edge that ends the execute cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (exec_valid && reg_we) begin
            regs[rd] <= wdata;
        end
    end

    // x0 hardwired
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: source/rv_core_top.sv
/* rv32i single-issue core */

`timescale 1ns/1ps

module rv_core_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 imem_valid,
    input  rv_isa_pkg::word_t    imem_data,
    output logic                 imem_req,
    output rv_isa_pkg::addr_t    imem_addr,
    output logic                 retire,
    output rv_isa_pkg::addr_t    retire_pc,
    output rv_isa_pkg::reg_idx_t retire_rd,
    output logic                 retire_we,
    output rv_isa_pkg::word_t    retire_wdata,
    output rv_isa_pkg::addr_t    retire_next_pc
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    word_t    instr;
    reg_idx_t rs1, rs2;
    word_t    imm;
    word_t    rs1_data, rs2_data;
    alu_op_t  alu_op;
    src_a_t   src_a;
    src_b_t   src_b;
    flow_t    flow;
    br_cond_t br_cond;
    wb_sel_t  wb_sel;

    fetch_unit u_fetch (
        .clk(clk), .reset(reset),
        .imem_valid(imem_valid), .imem_data(imem_data), .next_pc(retire_next_pc),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .pc(retire_pc), .instr(instr), .exec_valid(retire)
    );

    decode_unit u_decode (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(retire_rd), .imm(imm),
        .alu_op(alu_op), .src_a(src_a), .src_b(src_b), .flow(flow),
        .br_cond(br_cond), .wb_sel(wb_sel), .reg_we(retire_we)
    );

    gpr_file u_gpr (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(retire_rd),
        .wdata(retire_wdata), .exec_valid(retire), .reg_we(retire_we),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_unit u_execute (
        .pc(retire_pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .alu_op(alu_op), .src_a(src_a), .src_b(src_b), .flow(flow),
        .br_cond(br_cond), .wb_sel(wb_sel),
        .wdata(retire_wdata), .next_pc(retire_next_pc)
    );

endmodule

// File: source/rv_ctrl_pkg.sv
/* decode to execute control */

package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_t;

    typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_t;

    // how the next pc is formed
    typedef enum logic [1:0] {FLOW_SEQ, FLOW_BRANCH, FLOW_JAL, FLOW_JALR} flow_t;

    typedef enum logic [2:0] {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} br_cond_t;

    // register write value
    typedef enum logic {WB_ALU, WB_LINK} wb_sel_t;

endpackage

// File: source/rv_isa_pkg.sv
/* rv32i encoding types */

`include "rv_core_defines.svh"

package rv_isa_pkg;

    // data and instruction word
    typedef logic [`RV_XLEN-1:0] word_t;

    // byte address
    typedef logic [`RV_XLEN-1:0] addr_t;

    // general register number
    typedef logic [4:0] reg_idx_t;

    // fixed instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // encoding format, picks the immediate layout
    typedef enum logic [2:0] {
        FMT_R,     // reg-reg, no immediate
        FMT_I,     // 12 bit signed
        FMT_S,     // split 12 bit, stores
        FMT_B,     // branch offset, bit 0 implied
        FMT_U,     // upper 20 bits
        FMT_J,     // jal offset, bit 0 implied
        FMT_NONE   // not a kept opcode
    } inst_fmt_t;

endpackage
